//--- design/odd_pipe_defs.svh
`ifndef ODD_PIPE_DEFS_SVH
`define ODD_PIPE_DEFS_SVH

// datapath widths
`define QUAD_WIDTH 128
`define ADDR_WIDTH 32
`define REG_ADDR_WIDTH 7
`define IMM7_WIDTH 7
`define IMM16_WIDTH 16
`define COUNT_WIDTH 5

// forwarding pipe depth, one record per stage
`define FWD_DEPTH 7

// every branch address is masked to the local store size
`define LS_LIMIT 32'h0003_FFFF

// unit tags carried in the writeback record
`define PERMUTE_UNIT_ID 3'd5
`define BRANCH_UNIT_ID 3'd7

`endif

//--- design/odd_pipe_pkg.sv
`default_nettype none

`include "odd_pipe_defs.svh"

package odd_pipe_pkg;

    // permutes first, branches from OP_BR upward
    typedef enum logic [4:0] {
        OP_SHLQBI   = 5'd0,
        OP_SHLQBII  = 5'd1,
        OP_SHLQBY   = 5'd2,
        OP_SHLQBYI  = 5'd3,
        OP_SHLQBYBI = 5'd4,
        OP_ROTQBI   = 5'd5,
        OP_ROTQBII  = 5'd6,
        OP_ROTQBY   = 5'd7,
        OP_ROTQBYI  = 5'd8,
        OP_ROTQBYBI = 5'd9,
        OP_GBB      = 5'd10,
        OP_GBH      = 5'd11,
        OP_GB       = 5'd12,
        OP_BR       = 5'd13,
        OP_BRA      = 5'd14,
        OP_BRSL     = 5'd15,
        OP_BRASL    = 5'd16,
        OP_BRNZ     = 5'd17,
        OP_BRZ      = 5'd18,
        OP_BRHNZ    = 5'd19,
        OP_BRHZ     = 5'd20
    } op_t;

    // bit 0 is the most significant bit, element 0 the most significant element
    typedef logic [0:`QUAD_WIDTH-1] quad_t;
    typedef logic [0:`ADDR_WIDTH-1] pc_t;
    typedef logic [0:`REG_ADDR_WIDTH-1] reg_addr_t;
    typedef logic [0:2] unit_id_t;

    typedef struct packed {
        logic      valid;
        unit_id_t  unit;
        quad_t     value;
        logic      write;
        reg_addr_t address;
    } wb_record_t;

endpackage

`default_nettype wire

//--- design/result_if.sv
`timescale 1ns/1ns
`default_nettype none

// one unit's result on its way into the forwarding pipe
interface result_if
    import odd_pipe_pkg::*;
();

    logic      valid;
    quad_t     value;
    logic      write;
    reg_addr_t address;

    modport source (output valid, output value, output write, output address);
    modport sink (input valid, input value, input write, input address);

endinterface

`default_nettype wire

//--- design/issue_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "odd_pipe_defs.svh"

// registered instruction, already steered to one unit
interface issue_if
    import odd_pipe_pkg::*;
();

    logic                      perm_valid;
    logic                      branch_valid;
    op_t                       op;
    quad_t                     ra;
    quad_t                     rb;
    reg_addr_t                 rt_address;
    logic [0:`IMM16_WIDTH-1]   imm16;
    pc_t                       pc;
    logic [0:`COUNT_WIDTH-1]   count;

    modport source (
        output perm_valid, output branch_valid, output op, output ra, output rb,
        output rt_address, output imm16, output pc, output count
    );
    modport sink (
        input perm_valid, input branch_valid, input op, input ra, input rb,
        input rt_address, input imm16, input pc, input count
    );

endinterface

`default_nettype wire

//--- design/issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "odd_pipe_defs.svh"

module issue_stage
    import odd_pipe_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    issue_valid,
    input  wire op_t                     opcode,
    input  wire quad_t                   ra,
    input  wire quad_t                   rb,
    input  wire reg_addr_t               rt_address,
    input  wire logic [0:`IMM7_WIDTH-1]  imm7,
    input  wire logic [0:`IMM16_WIDTH-1] imm16,
    input  wire pc_t                     pc,
    issue_if.source                      issue
);

    logic                    is_branch;
    logic [0:`COUNT_WIDTH-1] next_count;

    assign is_branch = opcode inside {OP_BR, OP_BRA, OP_BRSL, OP_BRASL,
                                      OP_BRNZ, OP_BRZ, OP_BRHNZ, OP_BRHZ};

    // shift count taken from rb word 0 or imm7, masked per opcode
    always_comb
    begin
        case (opcode)
            OP_SHLQBI, OP_ROTQBI:
                next_count = {2'b00, rb[29:31]};
            OP_SHLQBII, OP_ROTQBII:
                next_count = {2'b00, imm7[4:6]};
            OP_SHLQBY:
                next_count = rb[27:31];
            OP_SHLQBYI:
                next_count = imm7[2:6];
            OP_ROTQBY:
                next_count = {1'b0, rb[28:31]};
            OP_ROTQBYI:
                next_count = {1'b0, imm7[3:6]};
            // bit count divided by eight
            OP_SHLQBYBI:
                next_count = rb[24:28];
            OP_ROTQBYBI:
                next_count = {1'b0, rb[25:28]};
            default:
                next_count = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            issue.perm_valid <= 1'b0;
            issue.branch_valid <= 1'b0;
        end
        else
        begin
            issue.perm_valid <= issue_valid && !is_branch;
            issue.branch_valid <= issue_valid && is_branch;
        end
    end

    // operands only load with a new instruction
    always_ff @(posedge clock)
    begin
        if (issue_valid)
        begin
            issue.op <= opcode;
            issue.ra <= ra;
            issue.rb <= rb;
            issue.rt_address <= rt_address;
            issue.imm16 <= imm16;
            issue.pc <= pc;
            issue.count <= next_count;
        end
    end

endmodule

`default_nettype wire

//--- design/permute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module permute_unit
    import odd_pipe_pkg::*;
(
    issue_if.sink    issue,
    result_if.source result
);

    logic [0:7]  bit_shift;
    logic [0:7]  byte_shift;
    logic [0:15] gather_bytes;
    logic [0:7]  gather_halves;
    logic [0:3]  gather_words;
    quad_t       rt_value;

    // a zero amount makes the right shift 128 wide, which clears that half
    function automatic quad_t rotate_left(input quad_t data, input logic [0:7] amount);
        return (data << amount) | (data >> (8'd128 - amount));
    endfunction

    assign bit_shift = {3'b000, issue.count};
    assign byte_shift = {issue.count, 3'b000};

    // lsb of each element, element 0 lands in the field msb
    always_comb
    begin
        for (int j = 0; j < 16; j++)
            gather_bytes[j] = issue.ra[j*8 + 7];
        for (int j = 0; j < 8; j++)
            gather_halves[j] = issue.ra[j*16 + 15];
        for (int j = 0; j < 4; j++)
            gather_words[j] = issue.ra[j*32 + 31];
    end

    always_comb
    begin
        rt_value = '0;
        case (issue.op)
            OP_SHLQBI, OP_SHLQBII:
                rt_value = issue.ra << bit_shift;
            // 16 bytes or more shifts by 128 bits or more and leaves zero
            OP_SHLQBY, OP_SHLQBYI, OP_SHLQBYBI:
                rt_value = issue.ra << byte_shift;
            OP_ROTQBI, OP_ROTQBII:
                rt_value = rotate_left(issue.ra, bit_shift);
            OP_ROTQBY, OP_ROTQBYI, OP_ROTQBYBI:
                rt_value = rotate_left(issue.ra, byte_shift);
            OP_GBB:
                rt_value[16:31] = gather_bytes;
            OP_GBH:
                rt_value[24:31] = gather_halves;
            OP_GB:
                rt_value[28:31] = gather_words;
            default:
                rt_value = '0;
        endcase
    end

    assign result.valid = issue.perm_valid;
    assign result.value = rt_value;
    assign result.write = 1'b1;
    assign result.address = issue.rt_address;

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "odd_pipe_defs.svh"

module branch_unit
    import odd_pipe_pkg::*;
(
    issue_if.sink    issue,
    result_if.source result,
    output logic     branch_valid,
    output logic     branch_taken,
    output pc_t      pc_next
);

    pc_t   offset;
    pc_t   rel_target;
    pc_t   abs_target;
    pc_t   cond_target;
    pc_t   link_target;
    logic  word_zero;
    logic  half_zero;
    logic  taken;
    quad_t rt_value;
    logic  rt_write;

    // word offset from the sign-extended 16-bit immediate
    assign offset = {{14{issue.imm16[0]}}, issue.imm16, 2'b00};
    assign rel_target = (issue.pc + offset) & `LS_LIMIT;
    assign abs_target = offset & `LS_LIMIT;
    assign cond_target = rel_target & 32'hFFFF_FFFC;
    assign link_target = (issue.pc + 32'd4) & `LS_LIMIT;

    // tested register value comes in on rb
    assign word_zero = issue.rb[0:31] == 32'd0;
    assign half_zero = issue.rb[16:31] == 16'd0;

    always_comb
    begin
        pc_next = link_target;
        taken = 1'b0;
        rt_value = '0;
        rt_write = 1'b0;
        case (issue.op)
            OP_BR, OP_BRSL:
            begin
                pc_next = rel_target;
                taken = 1'b1;
            end
            OP_BRA, OP_BRASL:
            begin
                pc_next = abs_target;
                taken = 1'b1;
            end
            OP_BRNZ, OP_BRZ, OP_BRHNZ, OP_BRHZ:
            begin
                taken = (issue.op == OP_BRNZ && !word_zero) ||
                        (issue.op == OP_BRZ && word_zero) ||
                        (issue.op == OP_BRHNZ && !half_zero) ||
                        (issue.op == OP_BRHZ && half_zero);
                // fall through keeps pc + 4
                if (taken)
                    pc_next = cond_target;
            end
            default:
                taken = 1'b0;
        endcase
        // link register gets the return address
        if (issue.op == OP_BRSL || issue.op == OP_BRASL)
        begin
            rt_value[0:31] = link_target;
            rt_write = 1'b1;
        end
    end

    assign branch_valid = issue.branch_valid;
    assign branch_taken = issue.branch_valid && taken;

    assign result.valid = issue.branch_valid;
    assign result.value = rt_value;
    assign result.write = rt_write;
    assign result.address = issue.rt_address;

endmodule

`default_nettype wire

//--- design/forward_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "odd_pipe_defs.svh"

module forward_pipe
    import odd_pipe_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    result_if.sink    permute,
    result_if.sink    branch,
    output logic      wb_valid,
    output unit_id_t  wb_unit,
    output quad_t     wb_value,
    output logic      wb_write,
    output reg_addr_t wb_address
);

    wb_record_t incoming;
    wb_record_t stage [1:`FWD_DEPTH];

    // at most one unit is valid per cycle
    always_comb
    begin
        incoming = '0;
        if (permute.valid)
        begin
            incoming.valid = 1'b1;
            incoming.unit = `PERMUTE_UNIT_ID;
            incoming.value = permute.value;
            incoming.write = permute.write;
            incoming.address = permute.address;
        end
        else if (branch.valid)
        begin
            incoming.valid = 1'b1;
            incoming.unit = `BRANCH_UNIT_ID;
            incoming.value = branch.value;
            incoming.write = branch.write;
            incoming.address = branch.address;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 1; i <= `FWD_DEPTH; i++)
                stage[i] <= '0;
        end
        else
        begin
            stage[1] <= incoming;
            for (int i = 2; i <= `FWD_DEPTH; i++)
                stage[i] <= stage[i-1];
        end
    end

    // last stage is the writeback
    assign wb_valid = stage[`FWD_DEPTH].valid;
    assign wb_unit = stage[`FWD_DEPTH].unit;
    assign wb_value = stage[`FWD_DEPTH].value;
    assign wb_write = stage[`FWD_DEPTH].write;
    assign wb_address = stage[`FWD_DEPTH].address;

endmodule

`default_nettype wire

//--- design/odd_pipe.sv
`timescale 1ns/1ns
`default_nettype none

`include "odd_pipe_defs.svh"

module odd_pipe
    import odd_pipe_pkg::*;
(
    input  wire logic                    clock,
    input  wire logic                    reset,
    input  wire logic                    issue_valid,
    input  wire op_t                     opcode,
    input  wire quad_t                   ra,
    input  wire quad_t                   rb,
    input  wire reg_addr_t               rt_address,
    input  wire logic [0:`IMM7_WIDTH-1]  imm7,
    input  wire logic [0:`IMM16_WIDTH-1] imm16,
    input  wire pc_t                     pc,
    output logic                         branch_valid,
    output logic                         branch_taken,
    output pc_t                          pc_next,
    output logic                         wb_valid,
    output unit_id_t                     wb_unit,
    output quad_t                        wb_value,
    output logic                         wb_write,
    output reg_addr_t                    wb_address
);

    issue_if  issue_bus ();
    result_if permute_result ();
    result_if branch_result ();

    issue_stage u_issue_stage (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .opcode      (opcode),
        .ra          (ra),
        .rb          (rb),
        .rt_address  (rt_address),
        .imm7        (imm7),
        .imm16       (imm16),
        .pc          (pc),
        .issue       (issue_bus.source)
    );

    permute_unit u_permute_unit (
        .issue  (issue_bus.sink),
        .result (permute_result.source)
    );

    branch_unit u_branch_unit (
        .issue        (issue_bus.sink),
        .result       (branch_result.source),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .pc_next      (pc_next)
    );

    forward_pipe u_forward_pipe (
        .clock      (clock),
        .reset      (reset),
        .permute    (permute_result.sink),
        .branch     (branch_result.sink),
        .wb_valid   (wb_valid),
        .wb_unit    (wb_unit),
        .wb_value   (wb_value),
        .wb_write   (wb_write),
        .wb_address (wb_address)
    );

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

// free-running testbench clock, 4 ns period
module clock_gen (
    output logic clock
);

    initial
    begin
        clock = 1'b0;
        forever
            #2 clock = ~clock;
    end

endmodule

`default_nettype wire

//--- tests/odd_pipe_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "odd_pipe_defs.svh"

module odd_pipe_tb
    import odd_pipe_pkg::*;
();

    typedef struct {
        string                      name;
        logic [4:0]                 op;
        logic [127:0]               ra;
        logic [127:0]               rb;
        logic [`IMM7_WIDTH-1:0]     imm7;
        logic [`IMM16_WIDTH-1:0]    imm16;
        logic [31:0]                pc;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [127:0]               value;
        logic                       write;
        logic                       taken;
        logic [31:0]                pc_next;
    } case_t;

    logic                    clock;
    logic                    reset;
    logic                    issue_valid;
    op_t                     opcode;
    quad_t                   ra;
    quad_t                   rb;
    reg_addr_t               rt_address;
    logic [0:`IMM7_WIDTH-1]  imm7;
    logic [0:`IMM16_WIDTH-1] imm16;
    pc_t                     pc;
    logic                    branch_valid;
    logic                    branch_taken;
    pc_t                     pc_next;
    logic                    wb_valid;
    unit_id_t                wb_unit;
    quad_t                   wb_value;
    logic                    wb_write;
    reg_addr_t               wb_address;

    case_t cases [$];
    bit    case_failed [$];
    // case index and due edge of every outstanding check
    int    branch_index [$];
    int    branch_due [$];
    int    wb_index [$];
    int    wb_due [$];
    int    edge_count = 0;
    int    error_count = 0;
    int    pass_count = 0;
    int    fail_count = 0;

    clock_gen u_clock_gen (
        .clock (clock)
    );

    odd_pipe u_odd_pipe (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .opcode       (opcode),
        .ra           (ra),
        .rb           (rb),
        .rt_address   (rt_address),
        .imm7         (imm7),
        .imm16        (imm16),
        .pc           (pc),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .pc_next      (pc_next),
        .wb_valid     (wb_valid),
        .wb_unit      (wb_unit),
        .wb_value     (wb_value),
        .wb_write     (wb_write),
        .wb_address   (wb_address)
    );

    function automatic logic is_branch_op(input logic [4:0] op);
        return op >= 5'd13;
    endfunction

    // permutes are unit 5, branches unit 7
    function automatic logic [2:0] unit_for_op(input logic [4:0] op);
        return is_branch_op(op) ? 3'd7 : 3'd5;
    endfunction

    task automatic check_value(input int id, input logic [127:0] actual,
                               input logic [127:0] expected, input string what);
        if (actual !== expected)
        begin
            if (id >= 0)
            begin
                $display("mismatch at %0t ns: case %0d %s %s got %0h expected %0h",
                         $time, id, cases[id].name, what, actual, expected);
                case_failed[id] = 1'b1;
            end
            else
                $display("mismatch at %0t ns: %s got %0h expected %0h",
                         $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_case(input int id);
        if (case_failed[id])
        begin
            $display("case %0d %s: failed", id, cases[id].name);
            fail_count++;
        end
        else
        begin
            $display("case %0d %s: ok", id, cases[id].name);
            pass_count++;
        end
    endtask

    task automatic load_cases();
        int                         fd;
        int                         count;
        int                         ch;
        string                      name;
        case_t                      c;
        logic [4:0]                 op_v;
        logic [127:0]               ra_v;
        logic [127:0]               rb_v;
        logic [127:0]               value_v;
        logic [`IMM7_WIDTH-1:0]     imm7_v;
        logic [`IMM16_WIDTH-1:0]    imm16_v;
        logic [31:0]                pc_v;
        logic [31:0]                next_v;
        logic [`REG_ADDR_WIDTH-1:0] rt_v;
        logic                       write_v;
        logic                       taken_v;
        fd = $fopen("tests/odd_pipe_cases.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open tests/odd_pipe_cases.txt");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", name) == 1)
        begin
            if (name.getc(0) == "#")
            begin
                // comment, drop the rest of the line
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
            end
            else
            begin
                count = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h", op_v, ra_v, rb_v,
                                imm7_v, imm16_v, pc_v, rt_v, value_v, write_v, taken_v,
                                next_v);
                if (count != 11)
                begin
                    $display("error: case %s has %0d of 11 fields", name, count);
                    error_count++;
                end
                else
                begin
                    c.name = name;
                    c.op = op_v;
                    c.ra = ra_v;
                    c.rb = rb_v;
                    c.imm7 = imm7_v;
                    c.imm16 = imm16_v;
                    c.pc = pc_v;
                    c.rt = rt_v;
                    c.value = value_v;
                    c.write = write_v;
                    c.taken = taken_v;
                    c.pc_next = next_v;
                    cases.push_back(c);
                    case_failed.push_back(1'b0);
                end
            end
        end
        $fclose(fd);
    endtask

    // sampled at edge k when driven 1 ns after edge k-1
    task automatic drive_case(input int i);
        issue_valid = 1'b1;
        opcode = op_t'(cases[i].op);
        ra = cases[i].ra;
        rb = cases[i].rb;
        imm7 = cases[i].imm7;
        imm16 = cases[i].imm16;
        pc = cases[i].pc;
        rt_address = cases[i].rt;
        if (is_branch_op(cases[i].op))
        begin
            branch_index.push_back(i);
            branch_due.push_back(edge_count + 1);
        end
        wb_index.push_back(i);
        wb_due.push_back(edge_count + 1 + `FWD_DEPTH);
    endtask

    task automatic check_branch();
        int id;
        if (branch_due.size() > 0 && branch_due[0] == edge_count)
        begin
            id = branch_index.pop_front();
            branch_due.delete(0);
            check_value(id, 128'(branch_valid), 128'(1'b1), "branch_valid");
            check_value(id, 128'(branch_taken), 128'(cases[id].taken), "branch_taken");
            check_value(id, 128'(pc_next), 128'(cases[id].pc_next), "pc_next");
        end
        else
            check_value(-1, 128'(branch_valid), 128'(1'b0), "idle branch_valid");
    endtask

    task automatic check_writeback();
        int id;
        int due;
        if (wb_valid === 1'b1)
        begin
            if (wb_index.size() == 0)
            begin
                $display("error at %0t ns: writeback with no instruction in flight", $time);
                error_count++;
            end
            else
            begin
                id = wb_index.pop_front();
                due = wb_due.pop_front();
                check_value(id, 128'(edge_count), 128'(due), "writeback edge");
                check_value(id, 128'(wb_unit), 128'(unit_for_op(cases[id].op)), "wb_unit");
                check_value(id, wb_value, cases[id].value, "wb_value");
                check_value(id, 128'(wb_write), 128'(cases[id].write), "wb_write");
                check_value(id, 128'(wb_address), 128'(cases[id].rt), "wb_address");
                report_case(id);
            end
        end
        else
        begin
            check_value(-1, 128'(wb_valid), 128'(1'b0), "idle wb_valid");
            if (wb_due.size() > 0 && wb_due[0] < edge_count)
            begin
                id = wb_index.pop_front();
                due = wb_due.pop_front();
                $display("error at %0t ns: case %0d %s never wrote back", $time, id,
                         cases[id].name);
                error_count++;
                case_failed[id] = 1'b1;
                report_case(id);
            end
        end
    endtask

    always @(posedge clock)
        edge_count <= edge_count + 1;

    // outputs are stable half a cycle after the edge
    always @(negedge clock)
    begin
        if (!reset)
        begin
            check_branch();
            check_writeback();
        end
    end

    initial
    begin
        int errors_before;
        int wait_count;
        reset = 1'b1;
        issue_valid = 1'b0;
        opcode = OP_BR;
        ra = '0;
        rb = '0;
        rt_address = '0;
        imm7 = '0;
        imm16 = '0;
        pc = '0;
        load_cases();
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;
        // nothing issued, so both valids must stay low
        errors_before = error_count;
        repeat (7) @(posedge clock);
        if (error_count == errors_before)
        begin
            $display("test reset idle: ok");
            pass_count++;
        end
        else
        begin
            $display("test reset idle: failed");
            fail_count++;
        end
        // back to back issue, one instruction per cycle
        for (int i = 0; i < cases.size(); i++)
        begin
            #1;
            drive_case(i);
            @(posedge clock);
        end
        #1;
        issue_valid = 1'b0;
        wait_count = 0;
        while (wb_index.size() > 0 && wait_count < 4 * `FWD_DEPTH)
        begin
            @(posedge clock);
            wait_count++;
        end
        if (wb_index.size() > 0)
        begin
            $display("timeout: %0d writebacks still outstanding", wb_index.size());
            error_count++;
        end
        if (pass_count + fail_count != cases.size() + 1)
        begin
            $display("error: %0d of %0d tests reported", pass_count + fail_count,
                     cases.size() + 1);
            error_count++;
        end
        $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
        if (error_count == 0 && fail_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/odd_pipe_cases.txt
# name opcode(decimal) ra rb, then on the next line in hex
#   imm7 imm16 pc rt value write taken pc_next (taken and pc_next unused for permutes)
shlqbi 0 00112233445566778899aabbccddeeff 00000003ffffffffffffffffffffffff
    00 0000 00000000 01 0089119a22ab33bc44cd55de66ef77f8 1 0 00000000
shlqbii 1 00112233445566778899aabbccddeeff 00000000000000000000000000000000
    0c 0000 00000000 02 0112233445566778899aabbccddeeff0 1 0 00000000
shlqby 2 00112233445566778899aabbccddeeff 00000005000000000000000000000000
    00 0000 00000000 03 5566778899aabbccddeeff0000000000 1 0 00000000
shlqbyi_19 3 00112233445566778899aabbccddeeff 00000000000000000000000000000000
    13 0000 00000000 04 00000000000000000000000000000000 1 0 00000000
shlqbybi 4 00112233445566778899aabbccddeeff 00000038000000000000000000000000
    00 0000 00000000 05 778899aabbccddeeff00000000000000 1 0 00000000
shlqbybi_16 4 00112233445566778899aabbccddeeff 00000080000000000000000000000000
    00 0000 00000000 06 00000000000000000000000000000000 1 0 00000000
rotqbi 5 8123456789abcdef0123456789abcdef 00000004000000000000000000000000
    00 0000 00000000 07 123456789abcdef0123456789abcdef8 1 0 00000000
rotqbii 6 8123456789abcdef0123456789abcdef 00000000000000000000000000000000
    09 0000 00000000 08 02468acf13579bde02468acf13579bdf 1 0 00000000
rotqby 7 8123456789abcdef0123456789abcdef 00000003000000000000000000000000
    00 0000 00000000 09 6789abcdef0123456789abcdef812345 1 0 00000000
rotqbyi 8 8123456789abcdef0123456789abcdef 00000000000000000000000000000000
    12 0000 00000000 0a 456789abcdef0123456789abcdef8123 1 0 00000000
rotqbybi 9 8123456789abcdef0123456789abcdef 00000088000000000000000000000000
    00 0000 00000000 0b 23456789abcdef0123456789abcdef81 1 0 00000000
gbb 10 01000101000100000101010100000001 00000000000000000000000000000000
    00 0000 00000000 0c 0000b4f1000000000000000000000000 1 0 00000000
gbh 11 0001ffff00000003fffe000500070002 00000000000000000000000000000000
    00 0000 00000000 0d 000000d6000000000000000000000000 1 0 00000000
gb 12 00000001fffffffe1234567980000000 00000000000000000000000000000000
    00 0000 00000000 0e 0000000a000000000000000000000000 1 0 00000000
br 13 00000000000000000000000000000000 00000000000000000000000000000000
    00 0010 00001000 10 00000000000000000000000000000000 0 1 00001040
bra 14 00000000000000000000000000000000 00000000000000000000000000000000
    00 fff0 00002000 11 00000000000000000000000000000000 0 1 0003ffc0
brsl 15 00000000000000000000000000000000 00000000000000000000000000000000
    00 ffff 80012344 12 00012348000000000000000000000000 1 1 00012340
brasl 16 00000000000000000000000000000000 00000000000000000000000000000000
    00 1234 00000100 13 00000104000000000000000000000000 1 1 000048d0
brnz_taken 17 00000000000000000000000000000000 00010000000000000000000000000000
    00 0008 00000400 14 00000000000000000000000000000000 0 1 00000420
brnz_not 17 00000000000000000000000000000000 00000000ffffffffffffffffffffffff
    00 0008 00000400 15 00000000000000000000000000000000 0 0 00000404
brz_taken 18 00000000000000000000000000000000 00000000ffffffffffffffffffffffff
    00 fffc 00050010 16 00000000000000000000000000000000 0 1 00010000
brz_not 18 00000000000000000000000000000000 00000001000000000000000000000000
    00 fffc 0003fffe 17 00000000000000000000000000000000 0 0 00000002
brhnz_taken 19 00000000000000000000000000000000 ffff0001000000000000000000000000
    00 0001 0000100e 18 00000000000000000000000000000000 0 1 00001010
brhnz_not 19 00000000000000000000000000000000 ffff0000000000000000000000000000
    00 0001 0000100e 19 00000000000000000000000000000000 0 0 00001012
brhz_taken 20 00000000000000000000000000000000 12340000000000000000000000000000
    00 8000 00002000 1a 00000000000000000000000000000000 0 1 00022000
brhz_not 20 00000000000000000000000000000000 00000100000000000000000000000000
    00 8000 00002000 1b 00000000000000000000000000000000 0 0 00002004

//--- odd_pipe.f
+incdir+design
design/odd_pipe_pkg.sv
design/result_if.sv
design/issue_if.sv
design/issue_stage.sv
design/permute_unit.sv
design/branch_unit.sv
design/forward_pipe.sv
design/odd_pipe.sv
tests/clock_gen.sv
tests/odd_pipe_tb.sv

//--- Makefile
# Verilator build and run of the odd pipe testbench

VERILATOR ?= verilator
TOP       ?= odd_pipe_tb
FILELIST  ?= odd_pipe.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
